//--- source/lsu_pkg.sv
package lsu_pkg;

    localparam int XLEN     = 32;
    localparam int BYTES    = 4;
    localparam int OFFSET_W = 2;
    localparam int REG_W    = 5;

    // value 3 is reserved
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } size_e;

    typedef enum logic [3:0] {
        EXC_NONE = 4'd0,
        EXC_LAM  = 4'd4,
        EXC_SAM  = 4'd6
    } exc_e;

    // wdata is right-aligned, as it comes from the register file
    typedef struct packed {
        logic             is_store;
        logic [XLEN-1:0]  base;
        logic [XLEN-1:0]  imm;
        size_e            size;
        logic             uext;
        logic [REG_W-1:0] rd;
        logic [XLEN-1:0]  wdata;
    } mem_req_t;

    typedef struct packed {
        logic             valid;
        logic             is_store;
        logic [XLEN-1:0]  addr;
        logic [BYTES-1:0] mask;
        logic             misalign;
        size_e            size;
        logic             uext;
        logic [REG_W-1:0] rd;
        logic [XLEN-1:0]  lane_data;
    } addr_stage_t;

    typedef union packed {
        logic [XLEN-1:0]       word;
        logic [BYTES-1:0][7:0] lanes;
    } mem_word_u;

    typedef struct packed {
        logic                valid;
        logic                is_store;
        logic [OFFSET_W-1:0] offset;
        size_e               size;
        logic                uext;
        logic [REG_W-1:0]    rd;
        logic                misalign;
        mem_word_u           rdata;
    } ram_stage_t;

    typedef struct packed {
        logic             valid;
        logic             is_store;
        logic [REG_W-1:0] rd;
        logic [XLEN-1:0]  data;
        exc_e             exc;
    } wb_t;

endpackage

//--- source/lsu_addr_stage.sv
`timescale 1ns/1ps

module lsu_addr_stage (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   req_valid_i,
    input  lsu_pkg::mem_req_t      req_i,
    output lsu_pkg::addr_stage_t   stage_o
);

    logic [lsu_pkg::XLEN-1:0]     addr;
    logic [lsu_pkg::OFFSET_W-1:0] offset;
    logic [lsu_pkg::BYTES-1:0]    mask;
    logic                         misalign;
    logic [lsu_pkg::XLEN-1:0]     lane_data;

    logic                         valid_q;
    lsu_pkg::addr_stage_t         payload_d;
    lsu_pkg::addr_stage_t         payload_q;

    // effective address wraps modulo 2^32
    assign addr   = req_i.base + req_i.imm;
    assign offset = addr[lsu_pkg::OFFSET_W-1:0];

    always_comb begin
        case (req_i.size)
            lsu_pkg::SIZE_WORD: begin
                mask     = '1;
                misalign = |offset;
            end
            lsu_pkg::SIZE_HALF: begin
                // top lane only at offset 3, the shift drops the rest
                mask     = lsu_pkg::BYTES'(2'b11) << offset;
                misalign = offset[0];
            end
            default: begin
                mask     = lsu_pkg::BYTES'(1'b1) << offset;
                misalign = 1'b0;
            end
        endcase
    end

    // move store data onto the lanes it will land in
    assign lane_data = req_i.wdata << {offset, 3'b000};

    always_comb begin
        payload_d.valid     = req_valid_i;
        payload_d.is_store  = req_i.is_store;
        payload_d.addr      = addr;
        payload_d.mask      = mask;
        payload_d.misalign  = misalign;
        payload_d.size      = req_i.size;
        payload_d.uext      = req_i.uext;
        payload_d.rd        = req_i.rd;
        payload_d.lane_data = lane_data;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        payload_q <= payload_d;
    end

    always_comb begin
        stage_o       = payload_q;
        stage_o.valid = valid_q;
    end

    // size 3 has no mask or alignment rule
    a_no_reserved_size: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        req_valid_i |-> req_i.size != 2'd3
    );

endmodule

//--- source/lsu_data_ram.sv
`timescale 1ns/1ps

module lsu_data_ram #(
    parameter int DEPTH_WORDS = 64
) (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  lsu_pkg::addr_stage_t   stage_i,
    output lsu_pkg::ram_stage_t    stage_o
);

    localparam int IDX_W = $clog2(DEPTH_WORDS);

    logic [lsu_pkg::BYTES-1:0][7:0] mem [DEPTH_WORDS];

    logic [IDX_W-1:0]    idx;
    logic                store_en;
    logic                valid_q;
    lsu_pkg::ram_stage_t payload_q;

    // upper address bits alias
    assign idx      = stage_i.addr[lsu_pkg::OFFSET_W +: IDX_W];
    assign store_en = stage_i.valid & stage_i.is_store & ~stage_i.misalign;

    always_ff @(posedge clk) begin
        for (int b = 0; b < lsu_pkg::BYTES; b++) begin
            if (store_en && stage_i.mask[b]) begin
                mem[idx][b] <= stage_i.lane_data[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= stage_i.valid;
        end
    end

    // read returns the word as it was before this edge's write
    always_ff @(posedge clk) begin
        if (stage_i.valid) begin
            payload_q.valid       <= 1'b1;
            payload_q.is_store    <= stage_i.is_store;
            payload_q.offset      <= stage_i.addr[lsu_pkg::OFFSET_W-1:0];
            payload_q.size        <= stage_i.size;
            payload_q.uext        <= stage_i.uext;
            payload_q.rd          <= stage_i.rd;
            payload_q.misalign    <= stage_i.misalign;
            payload_q.rdata.word  <= mem[idx];
        end
    end

    always_comb begin
        stage_o       = payload_q;
        stage_o.valid = valid_q;
    end

    // misaligned store leaves its word untouched
    a_misalign_no_write: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (stage_i.valid && stage_i.is_store && stage_i.misalign)
            |=> mem[$past(idx)] === $past(mem[idx])
    );

endmodule

//--- source/lsu_load_align.sv
`timescale 1ns/1ps

module lsu_load_align (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  lsu_pkg::ram_stage_t   stage_i,
    output lsu_pkg::wb_t          wb_o
);

    logic [lsu_pkg::OFFSET_W-1:0] idx1;
    logic [7:0]                   byte_data;
    logic [15:0]                  half_data;
    logic [lsu_pkg::XLEN-1:0]     load_data;
    logic [lsu_pkg::XLEN-1:0]     wb_data;
    lsu_pkg::exc_e                exc;

    logic                         valid_q;
    lsu_pkg::wb_t                 payload_q;

    // aligned halfwords never cross the word, so wrapping is harmless
    assign idx1      = stage_i.offset + 1'b1;
    assign byte_data = stage_i.rdata.lanes[stage_i.offset];
    assign half_data = {stage_i.rdata.lanes[idx1], byte_data};

    always_comb begin
        case (stage_i.size)
            lsu_pkg::SIZE_BYTE: begin
                load_data = {{(lsu_pkg::XLEN-8){~stage_i.uext & byte_data[7]}}, byte_data};
            end
            lsu_pkg::SIZE_HALF: begin
                load_data = {{(lsu_pkg::XLEN-16){~stage_i.uext & half_data[15]}}, half_data};
            end
            lsu_pkg::SIZE_WORD: begin
                load_data = stage_i.rdata.word;
            end
            default: begin
                load_data = '0;
            end
        endcase
    end

    always_comb begin
        if (!stage_i.misalign) begin
            exc = lsu_pkg::EXC_NONE;
        end else if (stage_i.is_store) begin
            exc = lsu_pkg::EXC_SAM;
        end else begin
            exc = lsu_pkg::EXC_LAM;
        end
    end

    // stores and faulting loads return zero
    assign wb_data = (stage_i.is_store || stage_i.misalign) ? '0 : load_data;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= stage_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        payload_q.valid    <= stage_i.valid;
        payload_q.is_store <= stage_i.is_store;
        payload_q.rd       <= stage_i.rd;
        payload_q.data     <= wb_data;
        payload_q.exc      <= exc;
    end

    always_comb begin
        wb_o       = payload_q;
        wb_o.valid = valid_q;
    end

    a_exc_zero_data: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (wb_o.valid && wb_o.exc != lsu_pkg::EXC_NONE) |-> wb_o.data == '0
    );

endmodule

//--- source/lsu_top.sv
`timescale 1ns/1ps

module lsu_top #(
    parameter int DEPTH_WORDS = 64
) (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                req_valid_i,
    input  lsu_pkg::mem_req_t   req_i,
    output lsu_pkg::wb_t        wb_o
);

    lsu_pkg::addr_stage_t addr_stage;
    lsu_pkg::ram_stage_t  ram_stage;

    // address, byte mask and lane shift
    lsu_addr_stage u_addr_stage (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .stage_o     (addr_stage)
    );

    lsu_data_ram #(
        .DEPTH_WORDS (DEPTH_WORDS)
    ) u_data_ram (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .stage_i (addr_stage),
        .stage_o (ram_stage)
    );

    // byte select, extension and writeback
    lsu_load_align u_load_align (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .stage_i (ram_stage),
        .wb_o    (wb_o)
    );

endmodule

//--- dv/lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb;

    localparam int DEPTH_WORDS = 64;
    localparam int MODEL_BYTES = DEPTH_WORDS * lsu_pkg::BYTES;
    localparam int DRAIN_LIMIT = 20;

    logic              clk;
    logic              rst_n_i;
    logic              req_valid_i;
    lsu_pkg::mem_req_t req_i;
    lsu_pkg::wb_t      wb_o;

    logic [7:0]   model_mem [MODEL_BYTES];
    lsu_pkg::wb_t exp_q [$];
    lsu_pkg::wb_t exp_wb;
    logic [4:0]   rd_next;
    int           error_count;
    int           tests_run;
    int           tests_ok;

    lsu_top #(
        .DEPTH_WORDS (DEPTH_WORDS)
    ) dut_i (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .wb_o        (wb_o)
    );

    always #10 clk = ~clk;

    // head of the expected queue, held stable until the next rising edge
    always @(negedge clk) begin
        if (rst_n_i && wb_o.valid) begin
            if (exp_q.size() == 0) begin
                $display("t=%0t a writeback arrived with no request pending", $time);
                error_count++;
            end else begin
                exp_wb = exp_q.pop_front();
            end
        end
    end

    a_wb_match: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        wb_o.valid |-> wb_o === exp_wb
    ) else begin
        $display("ERROR t=%0t wb_o expected %h got %h", $time, exp_wb, $sampled(wb_o));
        error_count++;
    end

    // sampled at edge N, wb_o registered at edge N+2 and first seen at edge N+3
    a_wb_latency: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        wb_o.valid == $past(req_valid_i, 3)
    ) else begin
        $display("ERROR t=%0t wb_o.valid expected %b got %b", $time,
                 !$sampled(wb_o.valid), $sampled(wb_o.valid));
        error_count++;
    end

    // memory model, updated in issue order
    function automatic lsu_pkg::wb_t model_access(input lsu_pkg::mem_req_t req);
        lsu_pkg::wb_t exp;
        logic [31:0]  addr;
        logic [31:0]  value;
        logic         misalign;
        int           nbytes;
        addr = req.base + req.imm;
        case (req.size)
            lsu_pkg::SIZE_BYTE: begin
                nbytes   = 1;
                misalign = 1'b0;
            end
            lsu_pkg::SIZE_HALF: begin
                nbytes   = 2;
                misalign = addr[0];
            end
            default: begin
                nbytes   = 4;
                misalign = (addr[1:0] != 2'b00);
            end
        endcase
        exp.valid    = 1'b1;
        exp.is_store = req.is_store;
        exp.rd       = req.rd;
        exp.data     = '0;
        exp.exc      = lsu_pkg::EXC_NONE;
        if (req.is_store) begin
            if (misalign) begin
                exp.exc = lsu_pkg::EXC_SAM;
            end else begin
                for (int i = 0; i < nbytes; i++) begin
                    model_mem[(addr + 32'(i)) % MODEL_BYTES] = req.wdata[8*i +: 8];
                end
            end
        end else if (misalign) begin
            exp.exc = lsu_pkg::EXC_LAM;
        end else begin
            value = '0;
            for (int i = 0; i < nbytes; i++) begin
                value[8*i +: 8] = model_mem[(addr + 32'(i)) % MODEL_BYTES];
            end
            if (!req.uext && value[8*nbytes-1]) begin
                for (int i = nbytes; i < 4; i++) begin
                    value[8*i +: 8] = 8'hFF;
                end
            end
            exp.data = value;
        end
        return exp;
    endfunction

    task automatic issue(input logic is_store, input logic [31:0] base,
                         input logic [31:0] imm, input lsu_pkg::size_e size,
                         input logic uext, input logic [31:0] wdata);
        lsu_pkg::mem_req_t req;
        req.is_store = is_store;
        req.base     = base;
        req.imm      = imm;
        req.size     = size;
        req.uext     = uext;
        req.rd       = rd_next;
        req.wdata    = wdata;
        rd_next      = rd_next + 5'd1;
        @(negedge clk);
        req_valid_i = 1'b1;
        req_i       = req;
        exp_q.push_back(model_access(req));
    endtask

    task automatic drain();
        int cycles;
        cycles = 0;
        @(negedge clk);
        req_valid_i = 1'b0;
        while (exp_q.size() != 0 && cycles < DRAIN_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d writebacks never arrived", exp_q.size());
            error_count++;
            exp_q.delete();
        end
        repeat (2) @(negedge clk);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        drain();
        tests_run++;
        if (error_count == errors_before) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, error_count - errors_before);
        end
    endtask

    task automatic check_idle_after_reset();
        int errors_before;
        errors_before = error_count;
        repeat (5) begin
            @(negedge clk);
            assert (wb_o.valid === 1'b0) else begin
                $display("ERROR t=%0t wb_o.valid expected 0 got %b", $time, wb_o.valid);
                error_count++;
            end
        end
        issue(1'b1, 32'h0000_0030, 32'h0000_0010, lsu_pkg::SIZE_WORD, 1'b0, 32'hDEAD_BEEF);
        issue(1'b0, 32'h0000_0040, 32'h0000_0000, lsu_pkg::SIZE_WORD, 1'b0, 32'h0);
        finish_test("reset and word store/load", errors_before);
    endtask

    task automatic check_subword_loads();
        int errors_before;
        errors_before = error_count;
        issue(1'b1, 32'h0000_0080, 32'h0, lsu_pkg::SIZE_WORD, 1'b0, 32'h80F1_7F82);
        for (int u = 0; u < 2; u++) begin
            for (int off = 0; off < 4; off++) begin
                issue(1'b0, 32'h0000_0080, 32'(off), lsu_pkg::SIZE_BYTE, u[0], 32'h0);
            end
            issue(1'b0, 32'h0000_0080, 32'h0, lsu_pkg::SIZE_HALF, u[0], 32'h0);
            issue(1'b0, 32'h0000_0080, 32'h2, lsu_pkg::SIZE_HALF, u[0], 32'h0);
        end
        finish_test("byte and halfword loads", errors_before);
    endtask

    task automatic check_subword_stores();
        int errors_before;
        errors_before = error_count;
        issue(1'b1, 32'h0000_00A0, 32'h0, lsu_pkg::SIZE_WORD, 1'b0, 32'h1122_3344);
        issue(1'b1, 32'h0000_00A0, 32'h1, lsu_pkg::SIZE_BYTE, 1'b0, 32'hFFFF_FFAB);
        issue(1'b0, 32'h0000_00A0, 32'h0, lsu_pkg::SIZE_WORD, 1'b0, 32'h0);
        issue(1'b1, 32'h0000_00A0, 32'h2, lsu_pkg::SIZE_HALF, 1'b0, 32'h5555_CDEF);
        issue(1'b0, 32'h0000_00A0, 32'h0, lsu_pkg::SIZE_WORD, 1'b0, 32'h0);
        issue(1'b1, 32'h0000_00A0, 32'h3, lsu_pkg::SIZE_BYTE, 1'b0, 32'h0000_0099);
        issue(1'b1, 32'h0000_00A0, 32'h0, lsu_pkg::SIZE_HALF, 1'b0, 32'h0000_7E01);
        issue(1'b0, 32'h0000_00A0, 32'h0, lsu_pkg::SIZE_WORD, 1'b0, 32'h0);
        finish_test("byte and halfword stores", errors_before);
    endtask

    task automatic check_misaligned();
        int errors_before;
        errors_before = error_count;
        issue(1'b1, 32'h0000_00C0, 32'h0, lsu_pkg::SIZE_WORD, 1'b0, 32'hA5A5_5A5A);
        issue(1'b0, 32'h0000_00C0, 32'h1, lsu_pkg::SIZE_WORD, 1'b0, 32'h0);
        issue(1'b0, 32'h0000_00C0, 32'h3, lsu_pkg::SIZE_HALF, 1'b1, 32'h0);
        issue(1'b1, 32'h0000_00C0, 32'h2, lsu_pkg::SIZE_WORD, 1'b0, 32'h0BAD_0BAD);
        issue(1'b1, 32'h0000_00C0, 32'h1, lsu_pkg::SIZE_HALF, 1'b0, 32'h0000_FFFF);
        issue(1'b0, 32'h0000_00C0, 32'h0, lsu_pkg::SIZE_WORD, 1'b0, 32'h0);
        finish_test("misaligned access", errors_before);
    endtask

    task automatic check_random_mix();
        int            errors_before;
        logic [31:0]   hi;
        logic [31:0]   addr;
        logic [31:0]   imm;
        logic [31:0]   prev_addr;
        logic          prev_store;
        logic          is_store;
        lsu_pkg::size_e size;
        errors_before = error_count;
        prev_addr     = '0;
        prev_store    = 1'b0;
        // fill the 16-word window so loads never see unwritten words
        for (int w = 0; w < 16; w++) begin
            hi = $urandom & 32'hFFFF_FF00;
            issue(1'b1, hi, 32'(4 * w), lsu_pkg::SIZE_WORD, 1'b0, $urandom);
        end
        for (int n = 0; n < 200; n++) begin
            is_store = $urandom_range(0, 1) == 1;
            size     = lsu_pkg::size_e'($urandom_range(0, 2));
            hi       = $urandom & 32'hFFFF_FF00;
            addr     = hi + 32'($urandom_range(0, 63));
            if (!is_store && prev_store && $urandom_range(0, 1) == 1) begin
                addr = {prev_addr[31:2], 2'($urandom_range(0, 3))};
            end
            imm = 32'($urandom_range(0, 63)) - 32'd32;
            issue(is_store, addr - imm, imm, size, $urandom_range(0, 1) == 1, $urandom);
            prev_addr  = addr;
            prev_store = is_store;
        end
        finish_test("random back-to-back mix", errors_before);
    endtask

    initial begin
        void'($urandom(32'h962d929d));
        clk         = 1'b0;
        rst_n_i     = 1'b0;
        req_valid_i = 1'b0;
        req_i       = '0;
        exp_wb      = '0;
        rd_next     = '0;
        error_count = 0;
        tests_run   = 0;
        tests_ok    = 0;
        repeat (10) @(negedge clk);
        rst_n_i = 1'b1;

        check_idle_after_reset();
        check_subword_loads();
        check_subword_stores();
        check_misaligned();
        check_random_mix();

        $display("tests run: %0d, ok: %0d, errors: %0d", tests_run, tests_ok, error_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- files.f
source/lsu_pkg.sv
source/lsu_addr_stage.sv
source/lsu_data_ram.sv
source/lsu_load_align.sv
source/lsu_top.sv
dv/lsu_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f files.f --top-module lsu_tb -o lsu_sim
./obj_dir/lsu_sim | tee sim.log

if grep -q "tests failed" sim.log; then
    exit 1
fi
exit 0
